// File: verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ===========================================================================
// core-wide sizes and fixed encodings
// ===========================================================================

`define WORD_W      32            // data and address width
`define REG_CNT     32            // architectural registers
`define HALT_OPCODE 6'h3f         // stops the core
`define RESET_PC    32'h0000_0000 // first fetch address

`endif

// File: verilog/cpu_types_pkg.sv
`include "cpu_consts.svh"

package cpu_types_pkg;

	// =======================================================================
	// instruction encodings
	// =======================================================================

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = `HALT_OPCODE
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_SLL, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
	} alu_op_t;

	// r-type layout; i-type immediate is {rd, shamt, funct}
	typedef struct packed {
		opcode_t    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} instr_fields_t;

endpackage

// File: verilog/pipe_types_pkg.sv
`include "cpu_consts.svh"

package pipe_types_pkg;
	import cpu_types_pkg::*;

	// =======================================================================
	// stage records
	// =======================================================================

	typedef struct packed {
		logic              valid;
		logic [`WORD_W-1:0] pcplus4;
		logic [`WORD_W-1:0] instr;
	} ifid_t;

	typedef struct packed {
		logic              valid;
		logic [`WORD_W-1:0] pcplus4;
		logic [`WORD_W-1:0] rdat1;
		logic [`WORD_W-1:0] rdat2;
		logic [`WORD_W-1:0] immext;
		logic [4:0]        shamt;
		logic [25:0]       jaddr;    // j-type target field
		logic [4:0]        rt;
		logic [4:0]        rd;
		logic              mem_to_reg;
		alu_op_t           alu_op;
		logic              alu_src;  // take immext as operand b
		logic              jtype;
		logic              reg_dst;  // write rd, else rt
		logic              reg_wen;
		logic              branch;
		logic              branch_ne;
		logic              halt;
		logic              dmem_wen;
		logic              dmem_ren;
	} idex_t;

	typedef struct packed {
		logic              wen;
		logic [4:0]        dest;
		logic [`WORD_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic              taken;
		logic [`WORD_W-1:0] target;
	} redirect_t;

	// =======================================================================
	// APB
	// =======================================================================

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [`WORD_W-1:0] paddr;
		logic [`WORD_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic              pready;
		logic [`WORD_W-1:0] prdata;
	} apb_rsp_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_SETUP, ARB_ACCESS} arb_state_t;

	typedef enum logic [1:0] {EXE_RUN, EXE_SETUP, EXE_ACCESS, EXE_HALTED} exe_state_t;

endpackage

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_unit import pipe_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  logic      hold,
	input  redirect_t redirect,
	input  logic      halted,
	output apb_req_t  req,
	input  apb_rsp_t  rsp,
	output ifid_t     ifid
);

	logic [`WORD_W-1:0] pc;
	apb_req_t req_q;
	ifid_t ifid_q;
	ifid_t buf_q;      // word that arrived while decode held
	ifid_t fetched;
	logic discard;     // in-flight read belongs to a squashed path
	logic stop;        // HALT already fetched, nothing beyond it
	logic done;
	logic keep;
	logic issue;

	assign done = req_q.psel & req_q.penable & rsp.pready;
	assign keep = done & !discard;
	assign issue = !req_q.psel & !buf_q.valid & !stop & !halted & !redirect.taken;
	assign fetched = '{valid: 1'b1, pcplus4: req_q.paddr + 32'd4, instr: rsp.prdata};

	assign req = req_q;
	assign ifid = ifid_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `RESET_PC;
			req_q <= '0;
			ifid_q <= '0;
			buf_q <= '0;
			discard <= 1'b0;
			stop <= 1'b0;
		end else begin
			// read request, one at a time
			if (done) begin
				req_q.psel <= 1'b0;
				req_q.penable <= 1'b0;
			end else if (req_q.psel) begin
				req_q.penable <= 1'b1;
			end else if (issue) begin
				req_q.psel <= 1'b1;
				req_q.paddr <= pc;
			end

			if (redirect.taken) begin
				pc <= redirect.target;
				ifid_q.valid <= 1'b0;
				buf_q.valid <= 1'b0;
				stop <= 1'b0;
				discard <= req_q.psel & !done; // let the bus finish, drop the word
			end else begin
				if (done)
					discard <= 1'b0;
				if (keep) begin
					pc <= fetched.pcplus4;
					stop <= (rsp.prdata[31:26] == `HALT_OPCODE);
				end
				if (!hold) begin
					if (buf_q.valid) begin
						ifid_q <= buf_q;
						buf_q.valid <= 1'b0;
					end else if (keep) begin
						ifid_q <= fetched;
					end else begin
						ifid_q.valid <= 1'b0;
					end
				end else if (keep) begin
					buf_q <= fetched;
				end
			end
		end
	end

endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_unit import cpu_types_pkg::*; import pipe_types_pkg::*; (
	input  logic  CLK,
	input  logic  nRST,
	input  ifid_t ifid,
	input  wb_t   wb,
	input  idex_t ex_dest,
	input  logic  flush,
	output idex_t decoded,
	output logic  stall
);

	logic [`WORD_W-1:0] regs [`REG_CNT];
	instr_fields_t f;
	logic [15:0] imm;
	logic uses_rt;
	logic [4:0] ex_dst;

	assign f = instr_fields_t'(ifid.instr);
	assign imm = ifid.instr[15:0];

	// reads see a same-cycle write-back
	function automatic logic [`WORD_W-1:0] rf_read(input logic [4:0] a);
		logic [`WORD_W-1:0] v;
		v = regs[a];
		if (wb.wen && wb.dest == a)
			v = wb.data;
		if (a == 5'd0)
			v = '0;
		return v;
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end else if (wb.wen && wb.dest != 5'd0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// ======================================================================
	// control decode
	// ======================================================================

	always_comb begin
		decoded = '0;
		decoded.alu_op = ALU_SLL;
		decoded.valid = ifid.valid & !flush;
		decoded.pcplus4 = ifid.pcplus4;
		decoded.rdat1 = rf_read(f.rs);
		decoded.rdat2 = rf_read(f.rt);
		decoded.immext = (f.opcode == OP_ORI) ? {16'h0, imm} : {{16{imm[15]}}, imm};
		decoded.shamt = f.shamt;
		decoded.jaddr = ifid.instr[25:0];
		decoded.rt = f.rt;
		decoded.rd = f.rd;

		if (ifid.valid) begin
			case (f.opcode)
				OP_RTYPE: begin
					decoded.reg_dst = 1'b1;
					decoded.reg_wen = 1'b1;
					case (f.funct)
						FN_SLL:  decoded.alu_op = ALU_SLL;
						FN_ADDU: decoded.alu_op = ALU_ADD;
						FN_SUBU: decoded.alu_op = ALU_SUB;
						FN_AND:  decoded.alu_op = ALU_AND;
						FN_OR:   decoded.alu_op = ALU_OR;
						FN_XOR:  decoded.alu_op = ALU_XOR;
						FN_SLT:  decoded.alu_op = ALU_SLT;
						default: decoded.reg_wen = 1'b0; // unsupported, runs as a nop
					endcase
				end
				OP_ADDIU: begin
					decoded.alu_op = ALU_ADD;
					decoded.alu_src = 1'b1;
					decoded.reg_wen = 1'b1;
				end
				OP_ORI: begin
					decoded.alu_op = ALU_OR;
					decoded.alu_src = 1'b1;
					decoded.reg_wen = 1'b1;
				end
				OP_LUI: begin
					decoded.alu_op = ALU_LUI;
					decoded.alu_src = 1'b1;
					decoded.reg_wen = 1'b1;
				end
				OP_LW: begin
					decoded.alu_op = ALU_ADD;
					decoded.alu_src = 1'b1;
					decoded.reg_wen = 1'b1;
					decoded.mem_to_reg = 1'b1;
					decoded.dmem_ren = 1'b1;
				end
				OP_SW: begin
					decoded.alu_op = ALU_ADD;
					decoded.alu_src = 1'b1;
					decoded.dmem_wen = 1'b1;
				end
				OP_BEQ, OP_BNE: begin
					decoded.alu_op = ALU_SUB;
					decoded.branch = 1'b1;
					decoded.branch_ne = (f.opcode == OP_BNE);
				end
				OP_J:    decoded.jtype = 1'b1;
				OP_HALT: decoded.halt = 1'b1;
				default: ;
			endcase
		end
	end

	// no forwarding, so wait out a producer sitting in idex
	assign uses_rt = (f.opcode == OP_RTYPE) | (f.opcode == OP_SW)
		| (f.opcode == OP_BEQ) | (f.opcode == OP_BNE);
	assign ex_dst = ex_dest.reg_dst ? ex_dest.rd : ex_dest.rt;
	assign stall = ifid.valid & !flush & ex_dest.valid & ex_dest.reg_wen & (ex_dst != 5'd0)
		& ((ex_dst == f.rs) | (uses_rt & (ex_dst == f.rt)));

endmodule

// File: verilog/idex.sv
`timescale 1ns/1ps

module idex import cpu_types_pkg::*; import pipe_types_pkg::*; (
	input  logic  CLK,
	input  logic  nRST,
	input  logic  write_en,
	input  logic  flush,
	input  idex_t d,
	output idex_t q
);

	// bubble record
	function automatic idex_t cleared_rec();
		idex_t r;
		r = '0;
		r.alu_op = ALU_SLL;
		return r;
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			q <= cleared_rec();
		end else if (flush) begin
			q <= cleared_rec();
		end else if (write_en) begin
			q <= d;
		end
	end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_unit import cpu_types_pkg::*; import pipe_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  idex_t     op,
	output apb_req_t  req,
	input  apb_rsp_t  rsp,
	output wb_t       wb,
	output redirect_t redirect,
	output logic      busy,
	output logic      halted
);

	exe_state_t state;
	apb_req_t req_q;
	wb_t wb_q;
	logic [`WORD_W-1:0] b;
	logic [`WORD_W-1:0] alu_y;
	logic [4:0] dst;
	logic mem_op;
	logic run;

	assign run = op.valid & (state == EXE_RUN);
	assign mem_op = op.valid & (op.dmem_ren | op.dmem_wen);
	assign b = op.alu_src ? op.immext : op.rdat2;
	assign dst = op.reg_dst ? op.rd : op.rt;

	always_comb begin
		case (op.alu_op)
			ALU_SLL: alu_y = b << op.shamt;
			ALU_ADD: alu_y = op.rdat1 + b;
			ALU_SUB: alu_y = op.rdat1 - b;
			ALU_AND: alu_y = op.rdat1 & b;
			ALU_OR:  alu_y = op.rdat1 | b;
			ALU_XOR: alu_y = op.rdat1 ^ b;
			ALU_SLT: alu_y = {{(`WORD_W-1){1'b0}}, $signed(op.rdat1) < $signed(b)};
			ALU_LUI: alu_y = {b[15:0], 16'h0};
		endcase
	end

	// resolved here, two younger instructions get dropped upstream
	assign redirect.taken = run & (op.jtype | (op.branch & ((op.rdat1 == op.rdat2) ^ op.branch_ne)));
	assign redirect.target = op.jtype ? {op.pcplus4[31:28], op.jaddr, 2'b00}
		: op.pcplus4 + {op.immext[29:0], 2'b00};

	assign busy = (run & mem_op) | (state == EXE_SETUP) | ((state == EXE_ACCESS) & !rsp.pready);
	assign halted = (state == EXE_HALTED);
	assign req = req_q;
	assign wb = wb_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= EXE_RUN;
			req_q <= '0;
			wb_q <= '0;
		end else begin
			wb_q.wen <= 1'b0; // one-cycle pulse
			case (state)
				EXE_RUN: begin
					if (op.valid & op.halt) begin
						state <= EXE_HALTED;
					end else if (mem_op) begin
						state <= EXE_SETUP;
						req_q <= '{psel: 1'b1, penable: 1'b0, pwrite: op.dmem_wen,
							paddr: alu_y, pwdata: op.rdat2};
					end else if (op.valid & op.reg_wen) begin
						wb_q <= '{wen: 1'b1, dest: dst, data: alu_y};
					end
				end
				EXE_SETUP: begin
					req_q.penable <= 1'b1;
					state <= EXE_ACCESS;
				end
				EXE_ACCESS: begin
					if (rsp.pready) begin
						req_q.psel <= 1'b0;
						req_q.penable <= 1'b0;
						state <= EXE_RUN;
						if (op.mem_to_reg)
							wb_q <= '{wen: op.reg_wen, dest: dst, data: rsp.prdata};
					end
				end
				EXE_HALTED: ; // final
			endcase
		end
	end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import pipe_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  apb_req_t fetch_req,
	output apb_rsp_t fetch_rsp,
	input  apb_req_t exe_req,
	output apb_rsp_t exe_rsp,
	output apb_req_t mem_req,
	input  apb_rsp_t mem_rsp
);

	arb_state_t state;
	logic own_exe;      // registered owner
	logic grant_exe;    // owner in effect this cycle
	logic access;
	logic other_waits;

	// at idle the grant is immediate, so the requester's own setup cycle goes out as is
	assign grant_exe = (state == ARB_IDLE) ? exe_req.psel : own_exe;
	assign access = (state == ARB_ACCESS);
	assign other_waits = own_exe ? fetch_req.psel : exe_req.psel;

	always_comb begin
		mem_req = grant_exe ? exe_req : fetch_req;
		if (!access)
			mem_req.penable = 1'b0; // a requester that waited is already in its access phase
	end

	assign fetch_rsp.prdata = mem_rsp.prdata;
	assign fetch_rsp.pready = mem_rsp.pready & access & !grant_exe;
	assign exe_rsp.prdata = mem_rsp.prdata;
	assign exe_rsp.pready = mem_rsp.pready & access & grant_exe;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= ARB_IDLE;
			own_exe <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (exe_req.psel | fetch_req.psel) begin
						own_exe <= exe_req.psel;
						state <= ARB_ACCESS;
					end
				end
				ARB_SETUP: state <= ARB_ACCESS;
				ARB_ACCESS: begin
					if (mem_rsp.pready) begin
						if (other_waits) begin
							own_exe <= !own_exe; // hand over with a fresh setup cycle
							state <= ARB_SETUP;
						end else begin
							state <= ARB_IDLE;
						end
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import pipe_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	output apb_req_t mem_req,
	input  apb_rsp_t mem_rsp,
	output logic     halted
);

	ifid_t ifid;
	idex_t decoded;
	idex_t ex_op;
	wb_t wb;
	redirect_t redirect;
	apb_req_t fetch_req;
	apb_req_t exe_req;
	apb_rsp_t fetch_rsp;
	apb_rsp_t exe_rsp;
	logic stall;
	logic busy;
	logic hold;
	logic idex_wen;
	logic idex_flush;

	assign hold = stall | busy;
	assign idex_wen = !hold;
	assign idex_flush = redirect.taken | (stall & !busy); // bubble behind a hazard

	fetch_unit fetch_i (.CLK, .nRST, .hold, .redirect, .halted,
		.req(fetch_req), .rsp(fetch_rsp), .ifid);

	decode_unit decode_i (.CLK, .nRST, .ifid, .wb, .ex_dest(ex_op),
		.flush(redirect.taken), .decoded, .stall);

	idex idex_i (.CLK, .nRST, .write_en(idex_wen), .flush(idex_flush),
		.d(decoded), .q(ex_op));

	execute_unit execute_i (.CLK, .nRST, .op(ex_op), .req(exe_req), .rsp(exe_rsp),
		.wb, .redirect, .busy, .halted);

	mem_arbiter arbiter_i (.CLK, .nRST, .fetch_req, .fetch_rsp, .exe_req, .exe_rsp,
		.mem_req, .mem_rsp);

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // 100 ns period
	end

	initial begin
		nRST = 1'b0;
		repeat (16) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb import cpu_types_pkg::*; import pipe_types_pkg::*; ();

	logic CLK;
	logic nRST;
	apb_req_t mem_req;
	apb_rsp_t mem_rsp;
	logic halted;

	logic [31:0] lfsr;
	logic [31:0] mem [256];       // memory behind the APB port
	logic [31:0] model_mem [256]; // image from the reference model
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic in_xfer;
	logic seen_first;
	logic [1:0] wait_cnt;
	apb_req_t xfer;               // request latched at its setup cycle

	tb_clock clk_i (.CLK, .nRST);

	cpu_core dut_i (.CLK, .nRST, .mem_req, .mem_rsp, .halted);

	// ========================================================================
	// helpers
	// ========================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(32'd1 + (rand_bits(3) % 32'd7)); // registers 1 to 7
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ========================================================================
	// program and reference model
	// ========================================================================

	task automatic gen_program();
		int pc;
		int op;
		int skip;
		int room;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'h3c5a_0000 ^ (32'(i) * 32'h0001_0003);
		pc = 0;
		for (int r = 1; r < 8; r++) begin
			mem[pc] = enc_i(OP_ADDIU, 5'd0, 5'(r), 16'(rand_bits(16)));
			pc++;
		end
		for (int k = 0; k < 40; k++) begin
			op = int'(rand_bits(4) % 32'd15);
			rs = pick_reg();
			rt = pick_reg();
			rd = pick_reg();
			imm = 16'(rand_bits(16));
			room = 46 - pc;     // never skip past the tail at word 47
			skip = int'(rand_bits(2));
			if (skip > room)
				skip = room;
			case (op)
				0: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_ADDU);
				1: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_SUBU);
				2: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_AND);
				3: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_OR);
				4: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_XOR);
				5: mem[pc] = enc_r(rs, rt, rd, 5'd0, FN_SLT);
				6: mem[pc] = enc_r(5'd0, rt, rd, 5'(rand_bits(5)), FN_SLL);
				7: mem[pc] = enc_i(OP_ADDIU, rs, rd, imm);
				8: mem[pc] = enc_i(OP_ORI, rs, rd, imm);
				9: mem[pc] = enc_i(OP_LUI, 5'd0, rd, imm);
				10: mem[pc] = enc_i(OP_LW, 5'd0, rd, 16'(32'd512 + 32'd4 * rand_bits(6)));
				11: mem[pc] = enc_i(OP_SW, 5'd0, rt, 16'(32'd512 + 32'd4 * rand_bits(6)));
				12: mem[pc] = enc_i(OP_BEQ, rs, rt, 16'(skip));
				13: mem[pc] = enc_i(OP_BNE, rs, rt, 16'(skip));
				default: mem[pc] = {6'(OP_J), 26'(pc + 1 + skip)};
			endcase
			pc++;
		end
		for (int r = 1; r < 8; r++) begin
			mem[pc] = enc_i(OP_SW, 5'd0, 5'(r), 16'(32'd796 + 32'd4 * 32'(r))); // words 200..206
			pc++;
		end
		mem[pc] = {`HALT_OPCODE, 26'd0};
	endtask

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] val;
		logic [4:0] dst;
		logic wr;
		int pc;
		int next;
		int steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = 0;
		steps = 0;
		while (model_mem[pc][31:26] != `HALT_OPCODE) begin
			if (steps > 1000)
				abort_run("reference model never reached HALT");
			steps++;
			ins = model_mem[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			next = pc + 1;
			wr = 1'b1;
			dst = ins[20:16];
			val = '0;
			case (ins[31:26])
				OP_RTYPE: begin
					dst = ins[15:11];
					case (ins[5:0])
						FN_ADDU: val = a + b;
						FN_SUBU: val = a - b;
						FN_AND:  val = a & b;
						FN_OR:   val = a | b;
						FN_XOR:  val = a ^ b;
						FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  val = b << ins[10:6];
						default: wr = 1'b0;
					endcase
				end
				OP_ADDIU: val = addr;
				OP_ORI:   val = a | {16'h0, ins[15:0]};
				OP_LUI:   val = {ins[15:0], 16'h0};
				OP_LW:    val = model_mem[addr[9:2]];
				OP_SW: begin
					wr = 1'b0;
					model_mem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ, OP_BNE: begin
					wr = 1'b0;
					if ((a == b) ^ (ins[31:26] == OP_BNE))
						next = pc + 1 + int'($signed(ins[15:0]));
				end
				OP_J: begin
					wr = 1'b0;
					next = int'(ins[25:0]);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0)
				regs[dst] = val;
			pc = next;
		end
	endtask

	// ========================================================================
	// APB memory with random wait states
	// ========================================================================

	initial begin
		mem_rsp = '0;
		in_xfer = 1'b0;
		seen_first = 1'b0;
		wait_cnt = '0;
		xfer = '0;
		forever begin
			@(posedge CLK);
			#1;
			mem_rsp.pready = 1'b0;
			if (mem_req.penable && !mem_req.psel) begin
				abort_run("penable high without psel");
			end else if (mem_req.psel && !mem_req.penable) begin
				if (in_xfer)
					abort_run("setup cycle inside an unfinished transfer");
				if (!seen_first) begin
					seen_first = 1'b1;
					check_eq("first access address", mem_req.paddr, `RESET_PC);
					check_eq("first access is a read", 32'(mem_req.pwrite), 32'd0);
				end
				check_eq("address inside memory", 32'(mem_req.paddr[31:10]), 32'd0);
				in_xfer = 1'b1;
				xfer = mem_req;
				wait_cnt = 2'(rand_bits(2));
			end else if (mem_req.psel) begin
				if (!in_xfer)
					abort_run("access cycle without a setup cycle");
				check_eq("paddr held", mem_req.paddr, xfer.paddr);
				check_eq("pwrite held", 32'(mem_req.pwrite), 32'(xfer.pwrite));
				if (xfer.pwrite)
					check_eq("pwdata held", mem_req.pwdata, xfer.pwdata);
				if (wait_cnt == 2'd0) begin
					mem_rsp.pready = 1'b1;
					mem_rsp.prdata = mem[xfer.paddr[9:2]];
					if (xfer.pwrite) begin
						mem[xfer.paddr[9:2]] = xfer.pwdata;
						got_addr.push_back(xfer.paddr);
						got_data.push_back(xfer.pwdata);
					end
					in_xfer = 1'b0;
				end else begin
					wait_cnt--;
				end
			end else if (in_xfer) begin
				abort_run("psel dropped before pready");
			end
		end
	end

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		int cycles;
		lfsr = 32'ha513;
		gen_program();
		for (int i = 0; i < 256; i++)
			model_mem[i] = mem[i];
		run_model();

		cycles = 0;
		@(negedge CLK);
		while (nRST !== 1'b1) begin
			check_eq("psel in reset", 32'(mem_req.psel), 32'd0);
			check_eq("penable in reset", 32'(mem_req.penable), 32'd0);
			check_eq("halted in reset", 32'(halted), 32'd0);
			cycles++;
			if (cycles > 40)
				abort_run("reset never released");
			@(negedge CLK);
		end
		// first cycle out of reset
		check_eq("psel after reset", 32'(mem_req.psel), 32'd0);
		check_eq("penable after reset", 32'(mem_req.penable), 32'd0);
		check_eq("halted after reset", 32'(halted), 32'd0);

		cycles = 0;
		while (!halted) begin
			@(negedge CLK);
			cycles++;
			if (cycles > 20000)
				abort_run("timed out waiting for halted");
		end
		repeat (50) begin
			@(negedge CLK);
			check_eq("halted stays high", 32'(halted), 32'd1);
			check_eq("no psel after halt", 32'(mem_req.psel), 32'd0);
		end

		check_eq("store count", 32'(got_addr.size()), 32'(exp_addr.size()));
		for (int i = 0; i < exp_addr.size(); i++) begin
			check_eq("store address", got_addr[i], exp_addr[i]);
			check_eq("store data", got_data[i], exp_data[i]);
		end
		for (int i = 128; i < 256; i++)
			check_eq("data word", mem[i], model_mem[i]);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: pipeline_cpu.f
+incdir+verilog
verilog/cpu_types_pkg.sv
verilog/pipe_types_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/idex.sv
verilog/execute_unit.sv
verilog/mem_arbiter.sv
verilog/cpu_core.sv
tb/tb_clock.sv
tb/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -f pipeline_cpu.f --top-module cpu_tb -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim \
	|| exit 1
